//--- source/axi_pkg.sv
/* axi widths and response codes */

package axi_pkg;

    // bus geometry
    localparam int AXI_ADDR_W  = 32;
    localparam int AXI_DATA_W  = 32;
    localparam int AXI_STRB_W  = AXI_DATA_W / 8;   // one enable per byte lane
    localparam int AXI_LEN_W   = 8;
    localparam int AXI_RESP_W  = 2;

    // axi3 INCR bursts stop at 16 beats
    localparam int AXI_MAX_LEN = 15;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;   // byte address
    typedef logic [AXI_DATA_W-1:0] axi_data_t;   // one beat
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [AXI_LEN_W-1:0]  axi_len_t;    // beats minus one
    typedef logic [AXI_RESP_W-1:0] axi_resp_t;

    // response codes, ordered so that a larger value is worse
    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_SLVERR = 2'd2;

endpackage

//--- source/l2_pkg.sv
/* l2 line geometry */

package l2_pkg;

    localparam int LINE_WORDS  = 4;
    localparam int LINE_BEAT_W = $clog2(LINE_WORDS);

    // word k of a line sits at bits 32k upward, strobe group k at 4k upward
    typedef logic [LINE_WORDS*axi_pkg::AXI_DATA_W-1:0] line_data_t;
    typedef logic [LINE_WORDS*axi_pkg::AXI_STRB_W-1:0] line_strb_t;
    typedef logic [LINE_BEAT_W-1:0]                    line_beat_t;

    // backing memory
    localparam int SRAM_WORDS   = 1024;
    localparam int SRAM_IDX_LSB = 2;      // word aligned
    localparam int SRAM_IDX_MSB = SRAM_IDX_LSB + $clog2(SRAM_WORDS) - 1;

    typedef logic [$clog2(SRAM_WORDS)-1:0] sram_idx_t;

endpackage

//--- source/l2_line_port.sv
/* l2 line port */
`timescale 1ns/1ps

module l2_line_port (
    input  logic                clk,
    input  logic                rstn,
    // cache read side
    input  logic                rd_req,
    input  axi_pkg::axi_addr_t  rd_addr,
    input  axi_pkg::axi_len_t   rd_len,
    output logic                rd_done,
    output l2_pkg::line_data_t  rd_line,
    output axi_pkg::axi_resp_t  rd_resp,
    // cache write side
    input  logic                wr_req,
    input  axi_pkg::axi_addr_t  wr_addr,
    input  axi_pkg::axi_len_t   wr_len,
    input  l2_pkg::line_data_t  wr_line,
    input  l2_pkg::line_strb_t  wr_strb,
    output logic                wr_done,
    output axi_pkg::axi_resp_t  wr_resp,
    // read channel toward the interface
    output logic                l2_rvalid,
    output axi_pkg::axi_addr_t  l2_raddr,
    output axi_pkg::axi_len_t   l2_rlen,
    input  logic                l2_raddrOK,
    input  logic                l2_rready,
    input  axi_pkg::axi_data_t  l2_rdata,
    input  axi_pkg::axi_resp_t  l2_rresp,
    input  logic                l2_rlast,
    // write channel toward the interface
    output logic                l2_wvalid,
    output logic                l2_wwvalid,
    output axi_pkg::axi_addr_t  l2_waddr,
    output axi_pkg::axi_len_t   l2_wlen,
    output axi_pkg::axi_data_t  l2_wdata,
    output axi_pkg::axi_strb_t  l2_wstrb,
    output logic                l2_wlast,
    input  logic                l2_waddrOK,
    input  logic                l2_wready,
    input  logic                l2_bvalid,
    output logic                l2_bready,
    input  axi_pkg::axi_resp_t  l2_bresp
);
    import axi_pkg::*;
    import l2_pkg::*;

    logic       rd_busy;
    logic       wr_busy;
    line_beat_t rd_beat;    // slot for the next read beat
    line_beat_t wr_beat;    // word being offered
    line_data_t wr_line_q;
    line_strb_t wr_strb_q;

    wire rd_start = rd_req && !rd_busy;
    wire wr_start = wr_req && !wr_busy;
    wire w_fire   = l2_wwvalid && l2_wready;
    wire b_fire   = l2_bvalid && l2_bready;

    // refill control
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_busy   <= 1'b0;
            l2_rvalid <= 1'b0;
            rd_done   <= 1'b0;
            rd_beat   <= '0;
        end else begin
            rd_done <= 1'b0;
            if (rd_start) begin
                rd_busy   <= 1'b1;
                l2_rvalid <= 1'b1;
                rd_beat   <= '0;
            end else begin
                if (l2_raddrOK)
                    l2_rvalid <= 1'b0;   // address has gone out
                if (l2_rready) begin
                    rd_beat <= rd_beat + 1'b1;
                    if (l2_rlast) begin
                        rd_busy <= 1'b0;
                        rd_done <= 1'b1;
                    end
                end
            end
        end
    end

    // refill line assembly with unread slots left at zero
    always_ff @(posedge clk) begin
        if (rd_start) begin
            l2_raddr <= rd_addr;
            l2_rlen  <= rd_len;
            rd_line  <= '0;
            rd_resp  <= RESP_OKAY;
        end else if (l2_rready) begin
            rd_line[rd_beat*AXI_DATA_W +: AXI_DATA_W] <= l2_rdata;
            if (l2_rresp > rd_resp)
                rd_resp <= l2_rresp;   // keep the worst
        end
    end

    // writeback control
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_busy    <= 1'b0;
            l2_wvalid  <= 1'b0;
            l2_wwvalid <= 1'b0;
            wr_beat    <= '0;
            wr_done    <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (wr_start) begin
                wr_busy    <= 1'b1;
                l2_wvalid  <= 1'b1;
                l2_wwvalid <= 1'b1;
                wr_beat    <= '0;
            end else begin
                if (l2_waddrOK)
                    l2_wvalid <= 1'b0;
                if (w_fire) begin
                    wr_beat <= wr_beat + 1'b1;
                    if (l2_wlast)
                        l2_wwvalid <= 1'b0;   // all beats sent
                end
                if (b_fire) begin
                    wr_busy <= 1'b0;
                    wr_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_start) begin
            l2_waddr  <= wr_addr;
            l2_wlen   <= wr_len;
            wr_line_q <= wr_line;
            wr_strb_q <= wr_strb;
        end
        if (b_fire)
            wr_resp <= l2_bresp;
    end

    // beat k takes word k and strobe group k
    assign l2_wdata  = wr_line_q[wr_beat*AXI_DATA_W +: AXI_DATA_W];
    assign l2_wstrb  = wr_strb_q[wr_beat*AXI_STRB_W +: AXI_STRB_W];
    assign l2_wlast  = (axi_len_t'(wr_beat) == l2_wlen);
    assign l2_bready = 1'b1;   // responses always taken

    // a line never holds more than LINE_WORDS beats
    assert property (@(posedge clk) disable iff (!rstn)
        rd_start |-> (rd_len < LINE_WORDS))
        else $error("read request longer than a line");
    assert property (@(posedge clk) disable iff (!rstn)
        wr_start |-> (wr_len < LINE_WORDS))
        else $error("write request longer than a line");

endmodule

//--- source/l2_axi_interface.sv
/* l2 to axi channel bridge */
`timescale 1ns/1ps

module l2_axi_interface (
    input  logic                clk,
    input  logic                rstn,
    // read side of the line port
    input  logic                l2_rvalid,
    input  axi_pkg::axi_addr_t  l2_raddr,
    input  axi_pkg::axi_len_t   l2_rlen,
    output logic                l2_raddrOK,
    output logic                l2_rready,    // marks a valid read beat
    output axi_pkg::axi_data_t  l2_rdata,
    output axi_pkg::axi_resp_t  l2_rresp,
    output logic                l2_rlast,
    // write side of the line port
    input  logic                l2_wvalid,
    input  logic                l2_wwvalid,
    input  axi_pkg::axi_addr_t  l2_waddr,
    input  axi_pkg::axi_len_t   l2_wlen,
    input  axi_pkg::axi_data_t  l2_wdata,
    input  axi_pkg::axi_strb_t  l2_wstrb,
    input  logic                l2_wlast,
    output logic                l2_waddrOK,
    output logic                l2_wready,
    output logic                l2_bvalid,
    input  logic                l2_bready,
    output axi_pkg::axi_resp_t  l2_bresp,
    // AR
    output axi_pkg::axi_addr_t  araddr,
    output axi_pkg::axi_len_t   arlen,
    output logic                arvalid,
    input  logic                arready,
    // R
    input  axi_pkg::axi_data_t  rdata,
    input  axi_pkg::axi_resp_t  rresp,
    input  logic                rvalid,
    input  logic                rlast,
    output logic                rready,
    // AW
    output axi_pkg::axi_addr_t  awaddr,
    output axi_pkg::axi_len_t   awlen,
    output logic                awvalid,
    input  logic                awready,
    // W
    output axi_pkg::axi_data_t  wdata,
    output axi_pkg::axi_strb_t  wstrb,
    output logic                wvalid,
    output logic                wlast,
    input  logic                wready,
    // B
    input  axi_pkg::axi_resp_t  bresp,
    input  logic                bvalid,
    output logic                bready
);
    import axi_pkg::*;

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;

    rd_state_t rd_state, rd_next;
    wr_state_t wr_state, wr_next;
    axi_addr_t waddr_q;   // address of the burst in flight

    // read channel
    always_ff @(posedge clk) begin
        if (!rstn)
            rd_state <= RD_IDLE;
        else
            rd_state <= rd_next;
    end

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: if (l2_rvalid)         rd_next = RD_ADDR;
            RD_ADDR: if (arvalid && arready) rd_next = RD_DATA;
            RD_DATA: if (rvalid && rlast)    rd_next = RD_IDLE;
            default:                         rd_next = RD_IDLE;
        endcase
    end

    assign l2_rdata = rdata;
    assign l2_rresp = rresp;

    always_comb begin
        araddr     = '0;
        arlen      = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        l2_rready  = 1'b0;
        l2_rlast   = 1'b0;
        l2_raddrOK = 1'b0;
        case (rd_state)
            RD_ADDR: begin
                araddr  = l2_raddr;
                arlen   = l2_rlen;
                arvalid = l2_rvalid;
            end
            RD_DATA: begin
                araddr     = l2_raddr;
                rready     = 1'b1;
                l2_rready  = rvalid;
                l2_rlast   = rlast;
                l2_raddrOK = 1'b1;
            end
            default: ;
        endcase
    end

    // write channel
    always_ff @(posedge clk) begin
        if (!rstn)
            wr_state <= WR_IDLE;
        else
            wr_state <= wr_next;
    end

    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE: if (l2_wvalid)                wr_next = WR_ADDR;
            WR_ADDR: if (awvalid && awready)       wr_next = WR_DATA;
            WR_DATA: if (wvalid && wready && wlast) wr_next = WR_RESP;
            WR_RESP: if (bvalid && bready)         wr_next = WR_IDLE;
            default:                               wr_next = WR_IDLE;
        endcase
    end

    assign awlen    = l2_wlen;
    assign wdata    = l2_wdata;
    assign wstrb    = l2_wstrb;
    assign l2_bresp = bresp;

    always_ff @(posedge clk) begin
        if (awvalid && awready)
            waddr_q <= l2_waddr;
    end

    always_comb begin
        awaddr     = '0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        wlast      = 1'b0;
        bready     = 1'b0;
        l2_wready  = 1'b0;
        l2_bvalid  = 1'b0;
        l2_waddrOK = 1'b0;
        case (wr_state)
            WR_ADDR: begin
                awaddr  = l2_waddr;
                awvalid = 1'b1;
            end
            WR_DATA: begin
                awaddr     = waddr_q;
                wvalid     = l2_wwvalid;
                wlast      = l2_wlast;
                l2_wready  = wready;
                l2_waddrOK = 1'b1;
            end
            WR_RESP: begin
                awaddr    = waddr_q;
                bready    = l2_bready;
                l2_bvalid = bvalid;
            end
            default: ;
        endcase
    end

    // address requests stay up and steady until the slave takes them
    assert property (@(posedge clk) disable iff (!rstn)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)))
        else $error("AR request dropped before accept");
    assert property (@(posedge clk) disable iff (!rstn)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr)))
        else $error("AW request dropped before accept");

endmodule

//--- source/axi_sram_slave.sv
/* axi burst slave over word sram */
`timescale 1ns/1ps

module axi_sram_slave (
    input  logic                clk,
    input  logic                rstn,
    input  axi_pkg::axi_addr_t  araddr,
    input  axi_pkg::axi_len_t   arlen,
    input  logic                arvalid,
    output logic                arready,
    output axi_pkg::axi_data_t  rdata,
    output axi_pkg::axi_resp_t  rresp,
    output logic                rvalid,
    output logic                rlast,
    input  logic                rready,
    input  axi_pkg::axi_addr_t  awaddr,
    input  axi_pkg::axi_len_t   awlen,
    input  logic                awvalid,
    output logic                awready,
    input  axi_pkg::axi_data_t  wdata,
    input  axi_pkg::axi_strb_t  wstrb,
    input  logic                wvalid,
    input  logic                wlast,
    output logic                wready,
    output axi_pkg::axi_resp_t  bresp,
    output logic                bvalid,
    input  logic                bready
);
    import axi_pkg::*;
    import l2_pkg::*;

    axi_data_t mem [SRAM_WORDS];

    sram_idx_t rd_idx, rd_fetch;
    axi_len_t  rd_cnt, rd_len_q;
    logic      rd_oor;
    sram_idx_t wr_idx;
    axi_len_t  wr_cnt, wr_len_q;
    logic      wr_oor;

    wire ar_fire = arvalid && arready;
    wire r_fire  = rvalid && rready;
    wire aw_fire = awvalid && awready;
    wire w_fire  = wvalid && wready;
    wire b_fire  = bvalid && bready;

    // anything above bit 11 misses the memory
    wire ar_oor = |araddr[AXI_ADDR_W-1:SRAM_IDX_MSB+1];
    wire aw_oor = |awaddr[AXI_ADDR_W-1:SRAM_IDX_MSB+1];

    // read engine with rvalid doubling as the busy flag
    assign arready = !rvalid;
    assign rlast   = (rd_cnt == rd_len_q);
    assign rresp   = rd_oor ? RESP_SLVERR : RESP_OKAY;
    assign rd_fetch = ar_fire ? araddr[SRAM_IDX_MSB:SRAM_IDX_LSB] : rd_idx + 1'b1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rvalid <= 1'b0;
            rd_cnt <= '0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
            rd_cnt <= '0;
        end else if (r_fire) begin
            if (rlast)
                rvalid <= 1'b0;
            else
                rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // next word is fetched as the current one is taken
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_oor   <= ar_oor;
            rd_len_q <= arlen;
        end
        if (ar_fire || (r_fire && !rlast)) begin
            rd_idx <= rd_fetch;
            rdata  <= (ar_fire ? ar_oor : rd_oor) ? '0 : mem[rd_fetch];
        end
    end

    // write engine
    assign awready = !wready && !bvalid;
    assign bresp   = wr_oor ? RESP_SLVERR : RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wready <= 1'b0;
            bvalid <= 1'b0;
            wr_cnt <= '0;
        end else begin
            if (aw_fire) begin
                wready <= 1'b1;
                wr_cnt <= '0;
            end else if (w_fire) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (wlast) begin
                    wready <= 1'b0;
                    bvalid <= 1'b1;
                end
            end
            if (b_fire)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_idx   <= awaddr[SRAM_IDX_MSB:SRAM_IDX_LSB];
            wr_oor   <= aw_oor;
            wr_len_q <= awlen;
        end else if (w_fire) begin
            wr_idx <= wr_idx + 1'b1;
        end
    end

    // memory comes up zero after reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < SRAM_WORDS; i++)
                mem[i] <= '0;
        end else if (w_fire && !wr_oor) begin
            for (int b = 0; b < AXI_STRB_W; b++)
                if (wstrb[b])
                    mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
    end

    // master's beat count must line up with the AW length
    assert property (@(posedge clk) disable iff (!rstn)
        w_fire |-> (wlast == (wr_cnt == wr_len_q)))
        else $error("wlast not on beat awlen");
    assert property (@(posedge clk) disable iff (!rstn)
        ar_fire |-> (arlen <= AXI_MAX_LEN))
        else $error("read burst longer than axi3 allows");
    assert property (@(posedge clk) disable iff (!rstn)
        aw_fire |-> (awlen <= AXI_MAX_LEN))
        else $error("write burst longer than axi3 allows");

endmodule

//--- source/l2_mem_top.sv
/* l2 memory side top */
`timescale 1ns/1ps

module l2_mem_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                rd_req,
    input  axi_pkg::axi_addr_t  rd_addr,
    input  axi_pkg::axi_len_t   rd_len,
    output logic                rd_done,
    output l2_pkg::line_data_t  rd_line,
    output axi_pkg::axi_resp_t  rd_resp,
    input  logic                wr_req,
    input  axi_pkg::axi_addr_t  wr_addr,
    input  axi_pkg::axi_len_t   wr_len,
    input  l2_pkg::line_data_t  wr_line,
    input  l2_pkg::line_strb_t  wr_strb,
    output logic                wr_done,
    output axi_pkg::axi_resp_t  wr_resp
);
    import axi_pkg::*;

    // line port to bridge
    logic      l2_rvalid, l2_raddrOK, l2_rready, l2_rlast;
    axi_addr_t l2_raddr, l2_waddr;
    axi_len_t  l2_rlen, l2_wlen;
    axi_data_t l2_rdata, l2_wdata;
    axi_resp_t l2_rresp, l2_bresp;
    logic      l2_wvalid, l2_wwvalid, l2_wlast, l2_waddrOK, l2_wready;
    logic      l2_bvalid, l2_bready;
    axi_strb_t l2_wstrb;

    // bridge to slave
    axi_addr_t araddr, awaddr;
    axi_len_t  arlen, awlen;
    logic      arvalid, arready, rvalid, rready, rlast;
    axi_data_t rdata, wdata;
    axi_resp_t rresp, bresp;
    logic      awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    axi_strb_t wstrb;

    l2_line_port u_line_port (.*);

    l2_axi_interface u_axi_if (.*);

    axi_sram_slave u_sram (.*);

endmodule

//--- test/tb_l2_mem_top.sv
/* l2 memory side testbench */
`timescale 1ns/1ps

module tb_l2_mem_top;
    import axi_pkg::*;
    import l2_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_TXNS        = 94;   // all requests issued by the tests below
    localparam int WATCHDOG_CYCLES = NUM_TXNS * 20 + 100;

    logic       clk;
    logic       rstn;
    logic       rd_req;
    axi_addr_t  rd_addr;
    axi_len_t   rd_len;
    logic       rd_done;
    line_data_t rd_line;
    axi_resp_t  rd_resp;
    logic       wr_req;
    axi_addr_t  wr_addr;
    axi_len_t   wr_len;
    line_data_t wr_line;
    line_strb_t wr_strb;
    logic       wr_done;
    axi_resp_t  wr_resp;

    axi_data_t ref_mem [SRAM_WORDS];   // reference copy of the sram

    l2_mem_top UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic addr_in_range(axi_addr_t addr);
        return addr < axi_addr_t'(SRAM_WORDS * 4);
    endfunction

    function automatic axi_resp_t expect_resp(axi_addr_t addr);
        return addr_in_range(addr) ? RESP_OKAY : RESP_SLVERR;
    endfunction

    // words past the burst and out of range words read as zero
    function automatic line_data_t expect_line(axi_addr_t addr, axi_len_t len);
        line_data_t line;
        sram_idx_t  idx;
        line = '0;
        idx  = sram_idx_t'(addr >> 2);
        for (int k = 0; k <= int'(len); k++) begin
            if (addr_in_range(addr))
                line[32*k +: 32] = ref_mem[idx];
            idx = idx + 1'b1;
        end
        return line;
    endfunction

    task automatic update_model(axi_addr_t addr, axi_len_t len, line_data_t line,
                                line_strb_t strb);
        sram_idx_t idx;
        idx = sram_idx_t'(addr >> 2);
        if (addr_in_range(addr)) begin   // dropped writes leave the model alone
            for (int k = 0; k <= int'(len); k++) begin
                for (int b = 0; b < 4; b++)
                    if (strb[4*k + b])
                        ref_mem[idx][8*b +: 8] = line[32*k + 8*b +: 8];
                idx = idx + 1'b1;
            end
        end
    endtask

    task automatic check_line(line_data_t got, line_data_t exp, string what);
        if (got !== exp) begin
            $display("FAIL @ %0d ns: %s line %h, expected %h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_resp(axi_resp_t got, axi_resp_t exp, string what);
        if (got !== exp) begin
            $display("FAIL @ %0d ns: %s resp %0d, expected %0d", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // called and returns 1 ns after a rising edge
    task automatic do_write(axi_addr_t addr, axi_len_t len, line_data_t line,
                            line_strb_t strb);
        wr_addr = addr;
        wr_len  = len;
        wr_line = line;
        wr_strb = strb;
        wr_req  = 1'b1;
        @(posedge clk);
        #1;
        wr_req = 1'b0;
        while (!wr_done) begin
            @(posedge clk);
            #1;
        end
        check_resp(wr_resp, expect_resp(addr), "write");
        update_model(addr, len, line, strb);
    endtask

    task automatic do_read(axi_addr_t addr, axi_len_t len);
        line_data_t exp;
        exp     = expect_line(addr, len);
        rd_addr = addr;
        rd_len  = len;
        rd_req  = 1'b1;
        @(posedge clk);
        #1;
        rd_req = 1'b0;
        while (!rd_done) begin
            @(posedge clk);
            #1;
        end
        check_line(rd_line, exp, "read");
        check_resp(rd_resp, expect_resp(addr), "read");
    endtask

    task automatic test_full_line();
        $display("full line write and read back");
        do_write(32'h0000_0010, 8'd3, 128'hdead_beef_0123_4567_89ab_cdef_5a5a_a5a5, '1);
        do_read(32'h0000_0010, 8'd3);
    endtask

    task automatic test_partial_strobe();
        $display("partial strobe merge");
        do_write(32'h0000_0100, 8'd3, 128'h1111_1111_2222_2222_3333_3333_4444_4444, '1);
        do_write(32'h0000_0100, 8'd3, 128'haaaa_aaaa_bbbb_bbbb_cccc_cccc_dddd_dddd,
                 16'h5a3c);
        do_read(32'h0000_0100, 8'd3);
    endtask

    task automatic test_short_bursts();
        $display("short bursts");
        do_write(32'h0000_0200, 8'd3, 128'h0404_0404_0303_0303_0202_0202_0101_0101, '1);
        do_read(32'h0000_0200, 8'd0);
        do_read(32'h0000_0204, 8'd1);
    endtask

    task automatic test_out_of_range();
        $display("out of range access");
        do_write(32'h0000_1010, 8'd3, 128'hffff_0000_ffff_0000_ffff_0000_ffff_0000, '1);
        do_read(32'h0000_1010, 8'd3);
        do_read(32'h0000_0010, 8'd3);   // aliased word index that must stay untouched
    endtask

    task automatic test_parallel();
        $display("read and write in parallel");
        fork
            do_read(32'h0000_0200, 8'd3);
            do_write(32'h0000_0300, 8'd3, 128'h7777_6666_5555_4444_3333_2222_1111_0000,
                     '1);
        join
        do_read(32'h0000_0300, 8'd3);
    endtask

    task automatic test_random();
        axi_addr_t  addr;
        line_data_t line;
        $display("random writes and reads");
        for (int i = 0; i < 40; i++) begin
            addr = axi_addr_t'($urandom_range(SRAM_WORDS - LINE_WORDS)) << 2;
            line = {$urandom, $urandom, $urandom, $urandom};
            do_write(addr, axi_len_t'($urandom_range(LINE_WORDS - 1)), line,
                     line_strb_t'($urandom));
            do_read(addr, axi_len_t'($urandom_range(LINE_WORDS - 1)));
        end
    endtask

    initial begin
        clk     = 1'b0;
        rstn    = 1'b0;
        rd_req  = 1'b0;
        rd_addr = '0;
        rd_len  = '0;
        wr_req  = 1'b0;
        wr_addr = '0;
        wr_len  = '0;
        wr_line = '0;
        wr_strb = '0;
        for (int i = 0; i < SRAM_WORDS; i++)
            ref_mem[i] = '0;   // sram clears during reset
        void'($urandom(32'hcfe8_bdd6));
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_full_line();
        test_partial_strobe();
        test_short_bursts();
        test_out_of_range();
        test_parallel();
        test_random();
        $display("All tests passed!");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, a request never completed");
        $display("Test failures found");
        $fatal(1, "simulation hung");
    end

endmodule

//--- src.f
source/axi_pkg.sv
source/l2_pkg.sv
source/l2_line_port.sv
source/l2_axi_interface.sv
source/axi_sram_slave.sv
source/l2_mem_top.sv
test/tb_l2_mem_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the l2 memory side testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_l2_mem_top -o sim_tb_l2_mem_top \
    && ./obj_dir/sim_tb_l2_mem_top | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
